//--- src/app_stream_pkg.sv
package app_stream_pkg;

    // --------------------
    // Stream word layout
    // --------------------

    // Payload width of every stream word
    localparam int DATA_W = 32;

    // Destination field, bit 0 picks the host path by default
    localparam int DEST_W = 2;

    // --------------------
    // Buffering
    // --------------------

    // Words held by each stream FIFO
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage

//--- src/app_cfg_pkg.sv
package app_cfg_pkg;

    // --------------------
    // Register port
    // --------------------
    localparam int ADDR_W = 4;
    localparam int CNT_W  = 32;

    // Register map
    localparam logic [ADDR_W-1:0] ADDR_OUT_SEL    = ADDR_W'(0);
    localparam logic [ADDR_W-1:0] ADDR_PKT_COUNT  = ADDR_W'(1);
    localparam logic [ADDR_W-1:0] ADDR_WORD_COUNT = ADDR_W'(2);

    // Access FSM encodings
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_ACK     = 2'd1;
    localparam logic [1:0] ST_RELEASE = 2'd2;

    // One register word, seen either as plain data or as the output select
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [29:0] rsvd;
            logic        value;
            logic        enable;
        } sel;
    } cfg_word_u;

endpackage

//--- src/stream_fifo.sv
module stream_fifo (
    input  logic                              core_clk,
    input  logic                              rst_n,
    input  logic                              in_tvalid,
    output logic                              in_tready,
    input  logic [app_stream_pkg::DATA_W-1:0] in_tdata,
    input  logic                              in_tlast,
    input  logic [app_stream_pkg::DEST_W-1:0] in_tdest,
    output logic                              out_tvalid,
    input  logic                              out_tready,
    output logic [app_stream_pkg::DATA_W-1:0] out_tdata,
    output logic                              out_tlast,
    output logic [app_stream_pkg::DEST_W-1:0] out_tdest
);
    import app_stream_pkg::*;

    logic [DATA_W-1:0]  mem_data [FIFO_DEPTH];
    logic               mem_last [FIFO_DEPTH];
    logic [DEST_W-1:0]  mem_dest [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               wr_en;
    logic               rd_en;

    assign in_tready  = (count != (FIFO_AW+1)'(FIFO_DEPTH));
    assign out_tvalid = (count != '0);
    assign wr_en      = in_tvalid && in_tready;
    assign rd_en      = out_tvalid && out_tready;

    // Head of the queue straight from storage
    assign out_tdata = mem_data[rd_ptr];
    assign out_tlast = mem_last[rd_ptr];
    assign out_tdest = mem_dest[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= in_tdata;
            mem_last[wr_ptr] <= in_tlast;
            mem_dest[wr_ptr] <= in_tdest;
        end
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at the last slot
            if (wr_en) begin
                wr_ptr <= (wr_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy never passes the depth and a full FIFO has both pointers on one slot
    a_no_write_full: assert property (@(posedge core_clk) disable iff (!rst_n)
        (count <= (FIFO_AW+1)'(FIFO_DEPTH)) && (in_tready || (wr_ptr == rd_ptr)));

endmodule

//--- src/stream_demux.sv
module stream_demux (
    input  logic                              core_clk,
    input  logic                              rst_n,
    input  logic                              sel_enable,
    input  logic                              sel_value,
    input  logic                              in_tvalid,
    output logic                              in_tready,
    input  logic [app_stream_pkg::DATA_W-1:0] in_tdata,
    input  logic                              in_tlast,
    input  logic [app_stream_pkg::DEST_W-1:0] in_tdest,
    output logic                              a_tvalid,
    input  logic                              a_tready,
    output logic [app_stream_pkg::DATA_W-1:0] a_tdata,
    output logic                              a_tlast,
    output logic [app_stream_pkg::DEST_W-1:0] a_tdest,
    output logic                              b_tvalid,
    input  logic                              b_tready,
    output logic [app_stream_pkg::DATA_W-1:0] b_tdata,
    output logic                              b_tlast,
    output logic [app_stream_pkg::DEST_W-1:0] b_tdest
);
    logic in_pkt;
    logic held_b;
    logic pick_b;
    logic route_b;

    // Register override wins over tdest bit 0
    assign pick_b  = sel_enable ? sel_value : in_tdest[0];
    assign route_b = in_pkt ? held_b : pick_b;

    assign a_tvalid  = in_tvalid && !route_b;
    assign b_tvalid  = in_tvalid && route_b;
    assign in_tready = route_b ? b_tready : a_tready;

    assign a_tdata = in_tdata;
    assign a_tlast = in_tlast;
    assign a_tdest = in_tdest;
    assign b_tdata = in_tdata;
    assign b_tlast = in_tlast;
    assign b_tdest = in_tdest;

    // Route is frozen from the first presented word until tlast leaves
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt <= 1'b0;
            held_b <= 1'b0;
        end else if (in_tvalid) begin
            held_b <= route_b;
            in_pkt <= !(in_tready && in_tlast);
        end
    end

    a_route_held: assert property (@(posedge core_clk) disable iff (!rst_n)
        in_pkt |-> $stable(route_b));

endmodule

//--- src/stream_arbiter.sv
module stream_arbiter (
    input  logic                              core_clk,
    input  logic                              rst_n,
    input  logic                              app_tvalid,
    output logic                              app_tready,
    input  logic [app_stream_pkg::DATA_W-1:0] app_tdata,
    input  logic                              app_tlast,
    input  logic [app_stream_pkg::DEST_W-1:0] app_tdest,
    input  logic                              h2c_tvalid,
    output logic                              h2c_tready,
    input  logic [app_stream_pkg::DATA_W-1:0] h2c_tdata,
    input  logic                              h2c_tlast,
    input  logic [app_stream_pkg::DEST_W-1:0] h2c_tdest,
    output logic                              out_tvalid,
    input  logic                              out_tready,
    output logic [app_stream_pkg::DATA_W-1:0] out_tdata,
    output logic                              out_tlast,
    output logic [app_stream_pkg::DEST_W-1:0] out_tdest
);
    logic in_pkt;
    logic last_h2c;
    logic pick_h2c;
    logic grant_h2c;

    // --------------------
    // Grant selection
    // --------------------

    // Alternate when both wait, else serve whichever side has a word
    assign pick_h2c  = (app_tvalid && h2c_tvalid) ? !last_h2c : h2c_tvalid;
    assign grant_h2c = in_pkt ? last_h2c : pick_h2c;

    assign app_tready = out_tready && !grant_h2c;
    assign h2c_tready = out_tready && grant_h2c;

    // --------------------
    // Output mux
    // --------------------
    assign out_tvalid = grant_h2c ? h2c_tvalid : app_tvalid;
    assign out_tdata  = grant_h2c ? h2c_tdata  : app_tdata;
    assign out_tlast  = grant_h2c ? h2c_tlast  : app_tlast;
    assign out_tdest  = grant_h2c ? h2c_tdest  : app_tdest;

    // Grant locks on the first presented word and opens after tlast
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            last_h2c <= 1'b0;
        end else if (out_tvalid) begin
            last_h2c <= grant_h2c;
            in_pkt   <= !(out_tready && out_tlast);
        end
    end

endmodule

//--- src/reg_access_fsm.sv
module reg_access_fsm (
    input  logic                           core_clk,
    input  logic                           rst_n,
    input  logic                           reg_req,
    input  logic                           reg_wr,
    input  logic [app_cfg_pkg::ADDR_W-1:0] reg_addr,
    input  logic [31:0]                    reg_wdata,
    input  logic [app_cfg_pkg::CNT_W-1:0]  pkt_count,
    input  logic [app_cfg_pkg::CNT_W-1:0]  word_count,
    output logic                           reg_ack,
    output logic [31:0]                    reg_rdata,
    output logic                           sel_enable,
    output logic                           sel_value,
    output logic                           count_clear
);
    import app_cfg_pkg::*;

    logic [1:0] state;
    logic       start;
    cfg_word_u  wr_word;
    cfg_word_u  rd_word;

    // Access happens on the edge where the request is first seen
    assign start       = (state == ST_IDLE) && reg_req;
    assign reg_ack     = (state != ST_IDLE);
    assign wr_word.raw = reg_wdata;
    assign count_clear = start && reg_wr && (reg_addr == ADDR_PKT_COUNT);

    // --------------------
    // Read decode
    // --------------------
    always_comb begin
        rd_word.raw = '0;
        case (reg_addr)
            ADDR_OUT_SEL: begin
                rd_word.sel.enable = sel_enable;
                rd_word.sel.value  = sel_value;
            end
            ADDR_PKT_COUNT:  rd_word.raw = pkt_count;
            ADDR_WORD_COUNT: rd_word.raw = word_count;
            default:         rd_word.raw = '0;
        endcase
    end

    always_ff @(posedge core_clk) begin
        if (start) begin
            reg_rdata <= rd_word.raw;
        end
    end

    // --------------------
    // Handshake and select register
    // --------------------
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            sel_enable <= 1'b0;
            sel_value  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE:    if (reg_req) state <= ST_ACK;
                // First ack cycle, requester may already have let go
                ST_ACK:     state <= reg_req ? ST_RELEASE : ST_IDLE;
                ST_RELEASE: if (!reg_req) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
            if (start && reg_wr && (reg_addr == ADDR_OUT_SEL)) begin
                sel_enable <= wr_word.sel.enable;
                sel_value  <= wr_word.sel.value;
            end
        end
    end

    a_ack_after_req: assert property (@(posedge core_clk) disable iff (!rst_n)
        $rose(reg_ack) |-> $past(reg_req));

endmodule

//--- src/packet_counter.sv
module packet_counter (
    input  logic                          core_clk,
    input  logic                          rst_n,
    input  logic                          tvalid,
    input  logic                          tready,
    input  logic                          tlast,
    input  logic                          count_clear,
    output logic [app_cfg_pkg::CNT_W-1:0] pkt_count,
    output logic [app_cfg_pkg::CNT_W-1:0] word_count
);
    logic accept;

    // Only words that really leave the egress port count
    assign accept = tvalid && tready;

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_count  <= '0;
            word_count <= '0;
        end else if (count_clear) begin
            // Clear beats a word arriving in the same cycle
            pkt_count  <= '0;
            word_count <= '0;
        end else if (accept) begin
            word_count <= word_count + 1'b1;
            if (tlast) begin
                pkt_count <= pkt_count + 1'b1;
            end
        end
    end

endmodule

//--- src/app_datapath.sv
module app_datapath (
    input  logic                              core_clk,
    input  logic                              rst_n,
    input  logic                              igr_tvalid,
    output logic                              igr_tready,
    input  logic [app_stream_pkg::DATA_W-1:0] igr_tdata,
    input  logic                              igr_tlast,
    input  logic [app_stream_pkg::DEST_W-1:0] igr_tdest,
    input  logic                              h2c_tvalid,
    output logic                              h2c_tready,
    input  logic [app_stream_pkg::DATA_W-1:0] h2c_tdata,
    input  logic                              h2c_tlast,
    input  logic [app_stream_pkg::DEST_W-1:0] h2c_tdest,
    output logic                              c2h_tvalid,
    input  logic                              c2h_tready,
    output logic [app_stream_pkg::DATA_W-1:0] c2h_tdata,
    output logic                              c2h_tlast,
    output logic [app_stream_pkg::DEST_W-1:0] c2h_tdest,
    output logic                              egr_tvalid,
    input  logic                              egr_tready,
    output logic [app_stream_pkg::DATA_W-1:0] egr_tdata,
    output logic                              egr_tlast,
    output logic [app_stream_pkg::DEST_W-1:0] egr_tdest,
    input  logic                              reg_req,
    input  logic                              reg_wr,
    input  logic [app_cfg_pkg::ADDR_W-1:0]    reg_addr,
    input  logic [31:0]                       reg_wdata,
    output logic                              reg_ack,
    output logic [31:0]                       reg_rdata
);
    import app_stream_pkg::*;
    import app_cfg_pkg::*;

    // Ingress FIFO to demux
    logic              dmx_tvalid;
    logic              dmx_tready;
    logic [DATA_W-1:0] dmx_tdata;
    logic              dmx_tlast;
    logic [DEST_W-1:0] dmx_tdest;

    // Application path into the arbiter
    logic              app_tvalid;
    logic              app_tready;
    logic [DATA_W-1:0] app_tdata;
    logic              app_tlast;
    logic [DEST_W-1:0] app_tdest;

    // Arbiter to egress FIFO
    logic              arb_tvalid;
    logic              arb_tready;
    logic [DATA_W-1:0] arb_tdata;
    logic              arb_tlast;
    logic [DEST_W-1:0] arb_tdest;

    logic              sel_enable;
    logic              sel_value;
    logic              count_clear;
    logic [CNT_W-1:0]  pkt_count;
    logic [CNT_W-1:0]  word_count;

    // --------------------
    // Ingress side
    // --------------------
    stream_fifo igr_fifo (
        .core_clk   ( core_clk ),
        .rst_n      ( rst_n ),
        .in_tvalid  ( igr_tvalid ),
        .in_tready  ( igr_tready ),
        .in_tdata   ( igr_tdata ),
        .in_tlast   ( igr_tlast ),
        .in_tdest   ( igr_tdest ),
        .out_tvalid ( dmx_tvalid ),
        .out_tready ( dmx_tready ),
        .out_tdata  ( dmx_tdata ),
        .out_tlast  ( dmx_tlast ),
        .out_tdest  ( dmx_tdest )
    );

    // Output b goes straight to the host
    stream_demux stream_demux_inst (
        .core_clk   ( core_clk ),
        .rst_n      ( rst_n ),
        .sel_enable ( sel_enable ),
        .sel_value  ( sel_value ),
        .in_tvalid  ( dmx_tvalid ),
        .in_tready  ( dmx_tready ),
        .in_tdata   ( dmx_tdata ),
        .in_tlast   ( dmx_tlast ),
        .in_tdest   ( dmx_tdest ),
        .a_tvalid   ( app_tvalid ),
        .a_tready   ( app_tready ),
        .a_tdata    ( app_tdata ),
        .a_tlast    ( app_tlast ),
        .a_tdest    ( app_tdest ),
        .b_tvalid   ( c2h_tvalid ),
        .b_tready   ( c2h_tready ),
        .b_tdata    ( c2h_tdata ),
        .b_tlast    ( c2h_tlast ),
        .b_tdest    ( c2h_tdest )
    );

    // --------------------
    // Egress side
    // --------------------
    stream_arbiter stream_arbiter_inst (
        .core_clk   ( core_clk ),
        .rst_n      ( rst_n ),
        .app_tvalid ( app_tvalid ),
        .app_tready ( app_tready ),
        .app_tdata  ( app_tdata ),
        .app_tlast  ( app_tlast ),
        .app_tdest  ( app_tdest ),
        .h2c_tvalid ( h2c_tvalid ),
        .h2c_tready ( h2c_tready ),
        .h2c_tdata  ( h2c_tdata ),
        .h2c_tlast  ( h2c_tlast ),
        .h2c_tdest  ( h2c_tdest ),
        .out_tvalid ( arb_tvalid ),
        .out_tready ( arb_tready ),
        .out_tdata  ( arb_tdata ),
        .out_tlast  ( arb_tlast ),
        .out_tdest  ( arb_tdest )
    );

    stream_fifo egr_fifo (
        .core_clk   ( core_clk ),
        .rst_n      ( rst_n ),
        .in_tvalid  ( arb_tvalid ),
        .in_tready  ( arb_tready ),
        .in_tdata   ( arb_tdata ),
        .in_tlast   ( arb_tlast ),
        .in_tdest   ( arb_tdest ),
        .out_tvalid ( egr_tvalid ),
        .out_tready ( egr_tready ),
        .out_tdata  ( egr_tdata ),
        .out_tlast  ( egr_tlast ),
        .out_tdest  ( egr_tdest )
    );

    // Probe watches the egress port itself
    packet_counter packet_counter_inst (
        .core_clk    ( core_clk ),
        .rst_n       ( rst_n ),
        .tvalid      ( egr_tvalid ),
        .tready      ( egr_tready ),
        .tlast       ( egr_tlast ),
        .count_clear ( count_clear ),
        .pkt_count   ( pkt_count ),
        .word_count  ( word_count )
    );

    // --------------------
    // Register port
    // --------------------
    reg_access_fsm reg_access_fsm_inst (
        .core_clk    ( core_clk ),
        .rst_n       ( rst_n ),
        .reg_req     ( reg_req ),
        .reg_wr      ( reg_wr ),
        .reg_addr    ( reg_addr ),
        .reg_wdata   ( reg_wdata ),
        .pkt_count   ( pkt_count ),
        .word_count  ( word_count ),
        .reg_ack     ( reg_ack ),
        .reg_rdata   ( reg_rdata ),
        .sel_enable  ( sel_enable ),
        .sel_value   ( sel_value ),
        .count_clear ( count_clear )
    );

endmodule

//--- verif/tb_app_datapath.sv
module tb_app_datapath;
    import app_stream_pkg::*;
    import app_cfg_pkg::*;

    localparam int WORD_W         = DEST_W + 1 + DATA_W;
    localparam int MAX_LEN        = 4;
    localparam int TOTAL_PKTS     = 42;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_PKTS * MAX_LEN + 2000;

    logic              core_clk;
    logic              rst_n;
    logic              igr_tvalid;
    logic              igr_tready;
    logic [DATA_W-1:0] igr_tdata;
    logic              igr_tlast;
    logic [DEST_W-1:0] igr_tdest;
    logic              h2c_tvalid;
    logic              h2c_tready;
    logic [DATA_W-1:0] h2c_tdata;
    logic              h2c_tlast;
    logic [DEST_W-1:0] h2c_tdest;
    logic              c2h_tvalid;
    logic              c2h_tready;
    logic [DATA_W-1:0] c2h_tdata;
    logic              c2h_tlast;
    logic [DEST_W-1:0] c2h_tdest;
    logic              egr_tvalid;
    logic              egr_tready;
    logic [DATA_W-1:0] egr_tdata;
    logic              egr_tlast;
    logic [DEST_W-1:0] egr_tdest;
    logic              reg_req;
    logic              reg_wr;
    logic [ADDR_W-1:0] reg_addr;
    logic [31:0]       reg_wdata;
    logic              reg_ack;
    logic [31:0]       reg_rdata;

    // Words kept as {tdest, tlast, tdata}, tdata bit 31 tags h2c traffic
    logic [WORD_W-1:0] igr_stage[$];
    logic [WORD_W-1:0] h2c_stage[$];
    logic [WORD_W-1:0] exp_c2h[$];
    logic [WORD_W-1:0] exp_egr_app[$];
    logic [WORD_W-1:0] exp_egr_h2c[$];
    logic [WORD_W-1:0] c2h_exp;
    logic [WORD_W-1:0] egr_exp;

    logic [31:0] lfsr = 32'h5a49;
    int          errors = 0;
    int          cycles = 0;
    int          egr_words = 0;
    int          egr_pkts = 0;
    logic        sel_en_m = 1'b0;
    logic        sel_val_m = 1'b0;
    logic        rand_ready = 1'b0;
    logic        egr_in_pkt = 1'b0;
    logic        egr_from_h2c = 1'b0;

    app_datapath dut0 (
        .core_clk   ( core_clk ),
        .rst_n      ( rst_n ),
        .igr_tvalid ( igr_tvalid ),
        .igr_tready ( igr_tready ),
        .igr_tdata  ( igr_tdata ),
        .igr_tlast  ( igr_tlast ),
        .igr_tdest  ( igr_tdest ),
        .h2c_tvalid ( h2c_tvalid ),
        .h2c_tready ( h2c_tready ),
        .h2c_tdata  ( h2c_tdata ),
        .h2c_tlast  ( h2c_tlast ),
        .h2c_tdest  ( h2c_tdest ),
        .c2h_tvalid ( c2h_tvalid ),
        .c2h_tready ( c2h_tready ),
        .c2h_tdata  ( c2h_tdata ),
        .c2h_tlast  ( c2h_tlast ),
        .c2h_tdest  ( c2h_tdest ),
        .egr_tvalid ( egr_tvalid ),
        .egr_tready ( egr_tready ),
        .egr_tdata  ( egr_tdata ),
        .egr_tlast  ( egr_tlast ),
        .egr_tdest  ( egr_tdest ),
        .reg_req    ( reg_req ),
        .reg_wr     ( reg_wr ),
        .reg_addr   ( reg_addr ),
        .reg_wdata  ( reg_wdata ),
        .reg_ack    ( reg_ack ),
        .reg_rdata  ( reg_rdata )
    );

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    // --------------------
    // Random source
    // --------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], take_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------

    // Builds one packet and files it under the output it must leave on
    task automatic gen_pkt(input logic from_h2c, input logic [DEST_W-1:0] dest);
        int                len;
        logic [31:0]       r;
        logic [WORD_W-1:0] w;
        logic              to_c2h;
        len = int'(rand_bits(2)) + 1;
        to_c2h = sel_en_m ? sel_val_m : dest[0];
        for (int i = 0; i < len; i++) begin
            r = rand_bits(31);
            w = {dest, (i == len - 1), from_h2c, r[30:0]};
            if (from_h2c) begin
                h2c_stage.push_back(w);
                exp_egr_h2c.push_back(w);
            end else begin
                igr_stage.push_back(w);
                if (to_c2h) begin
                    exp_c2h.push_back(w);
                end else begin
                    exp_egr_app.push_back(w);
                end
            end
        end
    endtask

    task automatic send_igr();
        logic [WORD_W-1:0] w;
        while (igr_stage.size() > 0) begin
            w = igr_stage.pop_front();
            igr_tvalid = 1'b1;
            {igr_tdest, igr_tlast, igr_tdata} = w;
            @(negedge core_clk);
            while (!igr_tready) @(negedge core_clk);
            @(posedge core_clk);
            #2;
        end
        igr_tvalid = 1'b0;
    endtask

    task automatic send_h2c();
        logic [WORD_W-1:0] w;
        while (h2c_stage.size() > 0) begin
            w = h2c_stage.pop_front();
            h2c_tvalid = 1'b1;
            {h2c_tdest, h2c_tlast, h2c_tdata} = w;
            @(negedge core_clk);
            while (!h2c_tready) @(negedge core_clk);
            @(posedge core_clk);
            #2;
        end
        h2c_tvalid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_c2h.size() + exp_egr_app.size() + exp_egr_h2c.size() != 0) begin
            @(negedge core_clk);
        end
        @(posedge core_clk);
        #2;
    endtask

    // Four-phase access, returns what was on reg_rdata during ack
    task automatic reg_access(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        reg_req = 1'b1;
        reg_wr = wr;
        reg_addr = addr;
        reg_wdata = wdata;
        @(negedge core_clk);
        while (!reg_ack) @(negedge core_clk);
        rdata = reg_rdata;
        @(posedge core_clk);
        #2;
        reg_req = 1'b0;
        @(negedge core_clk);
        while (reg_ack) @(negedge core_clk);
        @(posedge core_clk);
        #2;
    endtask

    task automatic read_expect(input logic [ADDR_W-1:0] addr, input string name,
                               input logic [31:0] exp);
        logic [31:0] rd;
        reg_access(1'b0, addr, '0, rd);
        check_value(name, rd, exp);
    endtask

    task automatic write_sel(input logic enable, input logic value);
        cfg_word_u   w;
        logic [31:0] rd;
        w.raw = '0;
        w.sel.enable = enable;
        w.sel.value = value;
        reg_access(1'b1, ADDR_OUT_SEL, w.raw, rd);
        read_expect(ADDR_OUT_SEL, "reg_rdata out_sel", w.raw);
        sel_en_m = enable;
        sel_val_m = value;
    endtask

    // --------------------
    // Output monitors
    // --------------------
    always @(negedge core_clk) begin
        if (rst_n && c2h_tvalid && c2h_tready) begin
            if (exp_c2h.size() == 0) begin
                errors++;
                $display("Unexpected word %h appeared on c2h", c2h_tdata);
            end else begin
                c2h_exp = exp_c2h.pop_front();
                check_value("c2h_tdata", c2h_tdata, c2h_exp[31:0]);
                check_value("c2h_tlast", 32'(c2h_tlast), 32'(c2h_exp[32]));
                check_value("c2h_tdest", 32'(c2h_tdest), 32'(c2h_exp[34:33]));
            end
        end
    end

    always @(negedge core_clk) begin
        if (rst_n && egr_tvalid && egr_tready) begin
            if (!egr_in_pkt) begin
                egr_from_h2c = egr_tdata[31];
            end
            if (egr_tdata[31] !== egr_from_h2c) begin
                errors++;
                $display("Packet on egr was interleaved with the other source");
            end else if (egr_from_h2c ? exp_egr_h2c.size() == 0
                                      : exp_egr_app.size() == 0) begin
                errors++;
                $display("Unexpected word %h appeared on egr", egr_tdata);
            end else begin
                egr_exp = egr_from_h2c ? exp_egr_h2c.pop_front() : exp_egr_app.pop_front();
                check_value("egr_tdata", egr_tdata, egr_exp[31:0]);
                check_value("egr_tlast", 32'(egr_tlast), 32'(egr_exp[32]));
                check_value("egr_tdest", 32'(egr_tdest), 32'(egr_exp[34:33]));
            end
            egr_in_pkt = !egr_tlast;
            egr_words++;
            if (egr_tlast) begin
                egr_pkts++;
            end
        end
    end

    // Output back-pressure, full rate unless a test asks for random stalls
    initial begin
        forever begin
            @(posedge core_clk);
            #2;
            if (rand_ready) begin
                egr_tready = take_bit();
                c2h_tready = take_bit();
            end else begin
                egr_tready = 1'b1;
                c2h_tready = 1'b1;
            end
        end
    end

    always @(posedge core_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, traffic or a handshake never finished",
                     cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_state();
        @(negedge core_clk);
        if (egr_tvalid !== 1'b0 || c2h_tvalid !== 1'b0 || reg_ack !== 1'b0) begin
            errors++;
            $display("An output valid or reg_ack is not low after reset");
        end
        @(posedge core_clk);
        #2;
        read_expect(ADDR_PKT_COUNT, "reg_rdata pkt_count", 32'h0);
        read_expect(ADDR_WORD_COUNT, "reg_rdata word_count", 32'h0);
        read_expect(ADDR_OUT_SEL, "reg_rdata out_sel", 32'h0);
    endtask

    task automatic test_default_routing();
        for (int i = 0; i < 6; i++) begin
            gen_pkt(1'b0, DEST_W'(i));
        end
        send_igr();
        wait_drain();
    endtask

    task automatic test_override();
        write_sel(1'b1, 1'b1);
        for (int i = 0; i < 4; i++) begin
            gen_pkt(1'b0, DEST_W'(i));
        end
        send_igr();
        wait_drain();
        write_sel(1'b1, 1'b0);
        for (int i = 0; i < 4; i++) begin
            gen_pkt(1'b0, DEST_W'(i));
        end
        send_igr();
        wait_drain();
    endtask

    task automatic test_merge();
        for (int i = 0; i < 6; i++) begin
            gen_pkt(1'b0, DEST_W'(i));
            gen_pkt(1'b1, DEST_W'(i));
        end
        fork
            send_igr();
            send_h2c();
        join
        wait_drain();
    endtask

    task automatic test_backpressure();
        logic [31:0] rd;
        write_sel(1'b0, 1'b0);
        reg_access(1'b1, ADDR_PKT_COUNT, 32'h0, rd);
        egr_words = 0;
        egr_pkts = 0;
        for (int i = 0; i < 10; i++) begin
            gen_pkt(1'b0, DEST_W'(i));
        end
        for (int i = 0; i < 6; i++) begin
            gen_pkt(1'b1, DEST_W'(i));
        end
        @(negedge core_clk);
        rand_ready = 1'b1;
        @(posedge core_clk);
        #2;
        fork
            send_igr();
            send_h2c();
        join
        wait_drain();
        @(negedge core_clk);
        rand_ready = 1'b0;
        @(posedge core_clk);
        #2;
        read_expect(ADDR_PKT_COUNT, "reg_rdata pkt_count", 32'(egr_pkts));
        read_expect(ADDR_WORD_COUNT, "reg_rdata word_count", 32'(egr_words));
        reg_access(1'b1, ADDR_PKT_COUNT, 32'hffff_ffff, rd);
        read_expect(ADDR_PKT_COUNT, "reg_rdata pkt_count", 32'h0);
        read_expect(ADDR_WORD_COUNT, "reg_rdata word_count", 32'h0);
    endtask

    initial begin
        rst_n = 1'b0;
        igr_tvalid = 1'b0;
        igr_tdata = '0;
        igr_tlast = 1'b0;
        igr_tdest = '0;
        h2c_tvalid = 1'b0;
        h2c_tdata = '0;
        h2c_tlast = 1'b0;
        h2c_tdest = '0;
        egr_tready = 1'b1;
        c2h_tready = 1'b1;
        reg_req = 1'b0;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        repeat (10) @(posedge core_clk);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        test_default_routing();
        test_override();
        test_merge();
        test_backpressure();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- project.f
src/app_stream_pkg.sv
src/app_cfg_pkg.sv
src/stream_fifo.sv
src/stream_demux.sv
src/stream_arbiter.sv
src/reg_access_fsm.sv
src/packet_counter.sv
src/app_datapath.sv
verif/tb_app_datapath.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_app_datapath \
    -f project.f -o sim_app_datapath > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_app_datapath > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
